//--- compile.f
+incdir+include
rtl/uop_pkg.sv
rtl/mem_pkg.sv
rtl/alu.sv
rtl/imul.sv
rtl/int_pipe.sv
rtl/mem_pipe.sv
rtl/exec_cluster.sv
dv/exec_cluster_chk.sv
dv/exec_cluster_tb.sv

//--- dv/exec_cluster_chk.sv
//////////////////////////////
// Execution cluster checker
// Issue and memory rules
//////////////////////////////

`timescale 1ns/1ps

module exec_cluster_chk import uop_pkg::*, mem_pkg::*; (
  input             clock,
  input             reset,
  input             issue_valid,
  input fu_code_t   fu_code,
  input             alu_stall,
  input             dmem_req,
  input             dmem_we,
  input             dmem_rvalid,
  input             mem_valid,
  input             int_valid,
  input tag_t       int_tag,
  input mem_state_t mem_state
);

  no_alu_issue_in_stall: assert property (@(posedge clock) disable iff (reset)
    issue_valid && (fu_code == FU_ALU || fu_code == FU_BR) |-> !alu_stall)
    else $error("ALU op issued while alu_stall was high");

  // A request only starts from idle on a memory issue
  req_from_idle_issue: assert property (@(posedge clock) disable iff (reset)
    $rose(dmem_req) |-> $past(mem_state == MS_IDLE && issue_valid && fu_code == FU_MEM))
    else $error("dmem_req rose without a memory issue in idle state");

  valid_after_accept: assert property (@(posedge clock) disable iff (reset)
    mem_valid |-> $past(dmem_req && (dmem_we || dmem_rvalid)))
    else $error("mem_valid without an accepted request");

  int_tag_known: assert property (@(posedge clock) disable iff (reset)
    int_valid |-> !$isunknown(int_tag))
    else $error("int_valid with unknown tag");

endmodule

bind exec_cluster exec_cluster_chk exec_cluster_chk_i (
  .clock       (clock),
  .reset       (reset),
  .issue_valid (issue_valid),
  .fu_code     (fu_code),
  .alu_stall   (alu_stall),
  .dmem_req    (dmem_req),
  .dmem_we     (dmem_we),
  .dmem_rvalid (dmem_rvalid),
  .mem_valid   (mem_valid),
  .int_valid   (int_valid),
  .int_tag     (int_tag),
  .mem_state   (mem_pipe_i.state)
);

//--- dv/exec_cluster_tb.sv
//////////////////////////////
// Execution cluster testbench
// Table driven issue, memory
// model and result checks
//////////////////////////////

`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_cluster_tb import uop_pkg::*, mem_pkg::*; ();

  typedef struct packed {
    fu_code_t  fu;
    logic [3:0] op;
    word_t     a;
    word_t     b;
    word_t     imm;
    mem_kind_t kind;
    mem_size_t size;
  } row_t;

  logic      clock;
  logic      reset;
  logic      issue_valid;
  fu_code_t  fu_code;
  alu_op_t   alu_op;
  mul_op_t   mul_op;
  mem_kind_t mem_kind;
  mem_size_t mem_size;
  tag_t      tag;
  word_t     in1;
  word_t     in2;
  word_t     imm;
  logic      alu_stall;
  logic      mem_busy;
  logic      int_valid;
  tag_t      int_tag;
  word_t     int_result;
  logic      mem_valid;
  tag_t      mem_tag;
  word_t     mem_result;
  logic      dmem_req;
  logic      dmem_we;
  addr_t     dmem_addr;
  byte_en_t  dmem_be;
  word_t     dmem_wdata;
  logic      dmem_rvalid;
  word_t     dmem_rdata;

  row_t        rows[$];
  word_t       dmem [64];
  word_t       ref_mem [64];
  word_t       exp_val [64];
  word_t       exp_word [64];
  int          exp_idx [64];
  int          exp_cyc [64];
  bit          exp_live [64];
  bit          exp_store [64];
  int          live_cnt;
  int          cyc;
  logic [31:0] lfsr_state;
  int          load_wait;
  int          draw;
  bit          mem_pending;
  tag_t        pend_tag;
  int          mem_issue_cyc;
  bit          mul_d1;
  bit          mul_d2;
  bit          mem_d1;
  logic [1:0]  mul_seen;

  exec_cluster exec_cluster_i (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cyc <= cyc + 1;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic bit lfsr_bit();
    bit fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  task automatic report_error(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1, "stopping on timeout");
  endtask

  function automatic word_t alu_rule(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT,
      ALU_BLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ALU_SLTU,
      ALU_BLTU: return (a < b) ? 1 : 0;
      ALU_BEQ:  return (a == b) ? 1 : 0;
      ALU_BNE:  return (a != b) ? 1 : 0;
      ALU_BGE:  return ($signed(a) >= $signed(b)) ? 1 : 0;
      default:  return (a >= b) ? 1 : 0;
    endcase
  endfunction

  function automatic word_t mul_rule(mul_op_t op, word_t a, word_t b);
    logic [63:0]        pu;
    logic signed [63:0] ps;
    pu = {32'b0, a} * {32'b0, b};
    ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    case (op)
      MUL_MUL:  return pu[31:0];
      MUL_MULH: return ps[63:32];
      default:  return pu[63:32];
    endcase
  endfunction

  // Store lands in the lanes picked by size and low address bits
  function automatic void store_rule(addr_t addr, mem_size_t size, word_t data);
    case (size)
      MEM_BYTE: ref_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
      MEM_HALF: ref_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
      default:  ref_mem[addr[7:2]] = data;
    endcase
  endfunction

  function automatic word_t load_rule(addr_t addr, mem_size_t size, mem_kind_t kind);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = ref_mem[addr[7:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (size)
      MEM_BYTE: return (kind == MEM_LD) ? {{24{b[7]}}, b} : {24'b0, b};
      MEM_HALF: return (kind == MEM_LD) ? {{16{h[15]}}, h} : {16'b0, h};
      default:  return w;
    endcase
  endfunction

  function automatic void add_row(fu_code_t fu, logic [3:0] op, word_t a, word_t b,
                                  word_t off = '0, mem_kind_t kind = MEM_LD,
                                  mem_size_t size = MEM_WORD);
    rows.push_back('{fu, op, a, b, off, kind, size});
  endfunction

  function automatic void add_mem(mem_kind_t kind, mem_size_t size, word_t base,
                                  word_t off, word_t data);
    add_row(FU_MEM, 4'd0, base, data, off, kind, size);
  endfunction

  function automatic void build_table();
    add_row(FU_ALU, ALU_ADD, 32'h7fff_ffff, 32'h1);
    add_row(FU_ALU, ALU_SUB, 32'h0, 32'h1);
    add_row(FU_ALU, ALU_AND, 32'hf0f0_1234, 32'h0ff0_ffff);
    add_row(FU_ALU, ALU_OR, 32'hf0f0_1234, 32'h0ff0_0001);
    add_row(FU_ALU, ALU_XOR, 32'haaaa_5555, 32'hffff_0000);
    add_row(FU_ALU, ALU_SLL, 32'h1, 32'h3f);
    add_row(FU_ALU, ALU_SRL, 32'h8000_0000, 32'h24);
    add_row(FU_ALU, ALU_SRA, 32'h8000_0000, 32'h4);
    add_row(FU_ALU, ALU_SLT, 32'hffff_ffff, 32'h1);
    add_row(FU_ALU, ALU_SLTU, 32'hffff_ffff, 32'h1);
    add_row(FU_BR, ALU_BEQ, 32'h5, 32'h5);
    add_row(FU_BR, ALU_BEQ, 32'h5, 32'h6);
    add_row(FU_BR, ALU_BNE, 32'h5, 32'h6);
    add_row(FU_BR, ALU_BLT, 32'hffff_fffb, 32'h3);
    add_row(FU_BR, ALU_BGE, 32'hffff_fffb, 32'h3);
    add_row(FU_BR, ALU_BLTU, 32'hffff_fffb, 32'h3);
    add_row(FU_BR, ALU_BGEU, 32'hffff_fffb, 32'h3);
    add_row(FU_BR, ALU_BGE, 32'h3, 32'h3);
    // Back-to-back multiplies
    add_row(FU_IMUL, MUL_MUL, 32'hffff_ffff, 32'hffff_ffff);
    add_row(FU_IMUL, MUL_MULH, 32'h8000_0000, 32'h8000_0000);
    add_row(FU_IMUL, MUL_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    add_row(FU_IMUL, MUL_MULH, 32'hffff_fffd, 32'h7);
    add_row(FU_IMUL, MUL_MULHU, 32'h8000_0000, 32'h3);
    // ALU ops mixed with multiplies
    add_row(FU_ALU, ALU_ADD, 32'd10, 32'd20);
    add_row(FU_IMUL, MUL_MUL, 32'h1234, 32'h5678);
    add_row(FU_ALU, ALU_SUB, 32'd5, 32'd9);
    add_row(FU_IMUL, MUL_MULH, 32'h7fff_ffff, 32'h8000_0001);
    add_row(FU_BR, ALU_BLT, 32'h1, 32'h2);
    for (int off = 0; off < 4; off++) begin
      add_mem(MEM_ST, MEM_BYTE, 32'd16, off, 32'h5a5a_5a80 ^ (off * 32'h23));
    end
    add_mem(MEM_ST, MEM_HALF, 32'd20, 0, 32'h1234_8001);
    add_mem(MEM_ST, MEM_HALF, 32'd20, 2, 32'h4321_7ffe);
    add_mem(MEM_ST, MEM_WORD, 32'd24, 0, 32'hdead_beef);
    for (int off = 0; off < 4; off++) begin
      add_mem(MEM_LD, MEM_BYTE, 32'd16, off, '0);
      add_mem(MEM_LDU, MEM_BYTE, 32'd16, off, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_mem(MEM_LD, MEM_HALF, 32'd20, off, '0);
      add_mem(MEM_LDU, MEM_HALF, 32'd20, off, '0);
    end
    add_mem(MEM_LD, MEM_WORD, 32'd24, 0, '0);
    add_mem(MEM_LDU, MEM_WORD, 32'd24, 0, '0);
    add_mem(MEM_LD, MEM_BYTE, 32'd40, 3, '0);
  endfunction

  // Data memory with a random load response delay
  always @(posedge clock) begin
    if (reset) begin
      dmem_rvalid <= 1'b0;
      load_wait = 0;
    end else begin
      if (dmem_req && dmem_we) begin
        for (int k = 0; k < 4; k++) begin
          if (dmem_be[k]) begin
            dmem[dmem_addr[7:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
          end
        end
      end
      if (dmem_rvalid) begin
        dmem_rvalid <= 1'b0;
      end else if (dmem_req && !dmem_we) begin
        if (load_wait == 0) begin
          draw = lfsr_bit();
          draw = 2 * draw + lfsr_bit();
          load_wait = 1 + draw;
        end
        load_wait--;
        if (load_wait == 0) begin
          dmem_rvalid <= 1'b1;
          dmem_rdata  <= dmem[dmem_addr[7:2]];
        end
      end
    end
  end

  task automatic check_result(input tag_t t, input word_t v);
    assert (exp_live[t]) else report_error($sformatf("unexpected tag %0d", t));
    assert (v == exp_val[t])
      else report_error($sformatf("tag %0d got %h expected %h", t, v, exp_val[t]));
    if (exp_cyc[t] >= 0) begin
      assert (cyc == exp_cyc[t])
        else report_error($sformatf("tag %0d at cycle %0d expected %0d", t, cyc, exp_cyc[t]));
    end
    if (exp_store[t]) begin
      assert (dmem[exp_idx[t]] == exp_word[t])
        else report_error($sformatf("store tag %0d memory %h expected %h",
                                    t, dmem[exp_idx[t]], exp_word[t]));
    end
    exp_live[t] = 1'b0;
    live_cnt--;
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      // Stall marks the cycle before the result slot of a multiply taken two edges back
      assert (alu_stall == mul_seen[1])
        else report_error($sformatf("alu_stall %b expected %b", alu_stall, mul_seen[1]));
      mul_seen = {mul_seen[0], issue_valid && fu_code == FU_IMUL};
      if (int_valid) begin
        check_result(int_tag, int_result);
      end
      if (mem_valid) begin
        check_result(mem_tag, mem_result);
      end
      if (mem_pending && cyc >= mem_issue_cyc + 2) begin
        assert (mem_busy) else report_error("mem_busy low before mem_valid");
      end
      if (mem_valid && mem_tag == pend_tag) begin
        mem_pending = 1'b0;
      end
    end
  end

  task automatic drive_idle();
    issue_valid <= 1'b0;
    mul_d2 = mul_d1;
    mul_d1 = 1'b0;
    mem_d1 = 1'b0;
  endtask

  task automatic drive_row(input int r);
    row_t  row;
    tag_t  t;
    addr_t addr;
    row  = rows[r];
    t    = tag_t'(r + 1);
    addr = row.a + row.imm;
    issue_valid <= 1'b1;
    fu_code     <= row.fu;
    alu_op      <= alu_op_t'(row.op);
    mul_op      <= mul_op_t'(row.op[1:0]);
    mem_kind    <= row.kind;
    mem_size    <= row.size;
    tag         <= t;
    in1         <= row.a;
    in2         <= row.b;
    imm         <= row.imm;
    exp_store[t] = 1'b0;
    case (row.fu)
      FU_IMUL: begin
        exp_val[t] = mul_rule(mul_op_t'(row.op[1:0]), row.a, row.b);
        exp_cyc[t] = cyc + 1 + `IMUL_LATENCY;
      end
      FU_MEM: begin
        if (row.kind == MEM_ST) begin
          store_rule(addr, row.size, row.b);
          exp_val[t]   = '0;
          exp_cyc[t]   = cyc + 3;
          exp_store[t] = 1'b1;
          exp_idx[t]   = addr[7:2];
          exp_word[t]  = ref_mem[addr[7:2]];
        end else begin
          exp_val[t] = load_rule(addr, row.size, row.kind);
          exp_cyc[t] = -1;
        end
        mem_pending   = 1'b1;
        pend_tag      = t;
        mem_issue_cyc = cyc;
      end
      default: begin
        exp_val[t] = alu_rule(alu_op_t'(row.op), row.a, row.b);
        exp_cyc[t] = cyc + 2;
      end
    endcase
    exp_live[t] = 1'b1;
    live_cnt++;
    mul_d2 = mul_d1;
    mul_d1 = (row.fu == FU_IMUL);
    mem_d1 = (row.fu == FU_MEM);
  endtask

  initial begin
    int  waited;
    bit  blocked;
    bit  busy_now;
    reset       = 1'b1;
    issue_valid = 1'b0;
    fu_code     = FU_ALU;
    alu_op      = ALU_ADD;
    mul_op      = MUL_MUL;
    mem_kind    = MEM_LD;
    mem_size    = MEM_WORD;
    tag         = '0;
    in1         = '0;
    in2         = '0;
    imm         = '0;
    dmem_rvalid = 1'b0;
    dmem_rdata  = '0;
    cyc         = 0;
    live_cnt    = 0;
    lfsr_state  = 32'h9c2b5d4a;
    mem_pending = 1'b0;
    mul_d1      = 1'b0;
    mul_d2      = 1'b0;
    mem_d1      = 1'b0;
    mul_seen    = 2'b00;
    for (int i = 0; i < 64; i++) begin
      dmem[i]     = 32'h3c96_0f5a ^ (i * 32'h0101_0107);
      ref_mem[i]  = dmem[i];
      exp_live[i] = 1'b0;
    end
    build_table();
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    foreach (rows[r]) begin
      waited = 0;
      do begin
        @(posedge clock);
        // Predicted multiply stall and memory busy window
        busy_now = mem_d1 || (mem_busy && !mem_valid);
        blocked  = ((rows[r].fu == FU_ALU || rows[r].fu == FU_BR) && mul_d2) ||
                   (rows[r].fu == FU_MEM && busy_now);
        if (blocked) begin
          drive_idle();
          waited++;
          if (waited > 200) begin
            report_timeout("issue slot");
          end
        end
      end while (blocked);
      drive_row(r);
    end
    @(posedge clock);
    drive_idle();
    waited = 0;
    while (live_cnt > 0) begin
      @(posedge clock);
      waited++;
      if (waited > 500) begin
        report_timeout("outstanding results");
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- include/exec_defines.svh
//////////////////////////////
// Execution cluster widths
// and multiplier depth
//////////////////////////////

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data word width
`define XLEN 32
// Destination tag width
`define TAG_W 6
// Cycles from multiplier issue to result
`define IMUL_LATENCY 3
// Data memory address width
`define ADDR_W 32

`endif

//--- rtl/alu.sv
//////////////////////////////
// Integer ALU
// Arithmetic, logic, shifts and
// branch compares, combinational
//////////////////////////////

`timescale 1ns/1ps

module alu import uop_pkg::*; (
  input  alu_op_t op,
  input  word_t   in1,
  input  word_t   in2,
  output word_t   result
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = in2[4:0];
  assign eq    = (in1 == in2);
  assign lt    = ($signed(in1) < $signed(in2));
  assign ltu   = (in1 < in2);

  always_comb begin
    case (op)
      ALU_ADD:  result = in1 + in2;
      ALU_SUB:  result = in1 - in2;
      ALU_AND:  result = in1 & in2;
      ALU_OR:   result = in1 | in2;
      ALU_XOR:  result = in1 ^ in2;
      ALU_SLL:  result = in1 << shamt;
      ALU_SRL:  result = in1 >> shamt;
      ALU_SRA:  result = word_t'($signed(in1) >>> shamt);
      ALU_SLT:  result = word_t'(lt);
      ALU_SLTU: result = word_t'(ltu);
      // Branches return 1 when taken
      ALU_BEQ:  result = word_t'(eq);
      ALU_BNE:  result = word_t'(!eq);
      ALU_BLT:  result = word_t'(lt);
      ALU_BGE:  result = word_t'(!lt);
      ALU_BLTU: result = word_t'(ltu);
      ALU_BGEU: result = word_t'(!ltu);
      default:  result = '0;
    endcase
  end

endmodule

//--- rtl/exec_cluster.sv
//////////////////////////////
// Execution cluster top
// Routes issue to integer and
// memory pipes
//////////////////////////////

`timescale 1ns/1ps

module exec_cluster import uop_pkg::*, mem_pkg::*; (
  input             clock,
  input             reset,
  input             issue_valid,
  input  fu_code_t  fu_code,
  input  alu_op_t   alu_op,
  input  mul_op_t   mul_op,
  input  mem_kind_t mem_kind,
  input  mem_size_t mem_size,
  input  tag_t      tag,
  input  word_t     in1,
  input  word_t     in2,
  input  word_t     imm,
  output            alu_stall,
  output            mem_busy,
  output            int_valid,
  output tag_t      int_tag,
  output word_t     int_result,
  output            mem_valid,
  output tag_t      mem_tag,
  output word_t     mem_result,
  output            dmem_req,
  output            dmem_we,
  output addr_t     dmem_addr,
  output byte_en_t  dmem_be,
  output word_t     dmem_wdata,
  input             dmem_rvalid,
  input  word_t     dmem_rdata
);

  logic int_issue;
  logic mem_issue;

  assign int_issue = issue_valid && (fu_code != FU_MEM);
  assign mem_issue = issue_valid && (fu_code == FU_MEM);

  int_pipe int_pipe_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (int_issue),
    .fu_code      (fu_code),
    .alu_op       (alu_op),
    .mul_op       (mul_op),
    .tag          (tag),
    .in1          (in1),
    .in2          (in2),
    .result_valid (int_valid),
    .result_tag   (int_tag),
    .result       (int_result),
    .alu_stall    (alu_stall)
  );

  mem_pipe mem_pipe_i (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (mem_issue),
    .mem_kind     (mem_kind),
    .mem_size     (mem_size),
    .tag          (tag),
    .in1          (in1),
    .in2          (in2),
    .imm          (imm),
    .busy         (mem_busy),
    .result_valid (mem_valid),
    .result_tag   (mem_tag),
    .result       (mem_result),
    .dmem_req     (dmem_req),
    .dmem_we      (dmem_we),
    .dmem_addr    (dmem_addr),
    .dmem_be      (dmem_be),
    .dmem_wdata   (dmem_wdata),
    .dmem_rvalid  (dmem_rvalid),
    .dmem_rdata   (dmem_rdata)
  );

endmodule

//--- rtl/imul.sv
//////////////////////////////
// Pipelined 32x32 multiplier
// Low or high product word
//////////////////////////////

`timescale 1ns/1ps
`include "exec_defines.svh"

module imul import uop_pkg::*; (
  input           clock,
  input           reset,
  input  mul_op_t op,
  input  word_t   in1,
  input  word_t   in2,
  output word_t   result
);

  mul_op_t                   op_q;
  word_t                     a_q;
  word_t                     b_q;
  logic signed [`XLEN:0]     a_ext;
  logic signed [`XLEN:0]     b_ext;
  logic signed [2*`XLEN+1:0] prod;
  word_t                     prod_word;
  word_t                     pipe_q [`IMUL_LATENCY-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      op_q <= MUL_MUL;
    end else begin
      op_q <= op;
    end
  end

  always_ff @(posedge clock) begin
    a_q <= in1;
    b_q <= in2;
  end

  // mulh extends by sign, mulhu by zero; one 33x33 signed multiply covers both
  assign a_ext = {(op_q == MUL_MULH) & a_q[`XLEN-1], a_q};
  assign b_ext = {(op_q == MUL_MULH) & b_q[`XLEN-1], b_q};
  assign prod  = a_ext * b_ext;

  assign prod_word = (op_q == MUL_MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];

  always_ff @(posedge clock) begin
    pipe_q[0] <= prod_word;
    for (int i = 1; i < `IMUL_LATENCY - 1; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

  assign result = pipe_q[`IMUL_LATENCY-2];

endmodule

//--- rtl/int_pipe.sv
//////////////////////////////
// Integer pipe
// ALU and multiplier merged onto
// one tagged result port
//////////////////////////////

`timescale 1ns/1ps
`include "exec_defines.svh"

module int_pipe import uop_pkg::*; (
  input            clock,
  input            reset,
  input            issue_valid,
  input  fu_code_t fu_code,
  input  alu_op_t  alu_op,
  input  mul_op_t  mul_op,
  input  tag_t     tag,
  input  word_t    in1,
  input  word_t    in2,
  output           result_valid,
  output tag_t     result_tag,
  output word_t    result,
  output           alu_stall
);

  logic                       alu_issue;
  logic                       mul_issue;
  word_t                      alu_out;
  word_t                      alu_q;
  word_t                      mul_out;
  logic [`IMUL_LATENCY-1:0]   slot_valid;
  logic [`IMUL_LATENCY-1:0]   slot_mul;
  tag_t                       slot_tag [`IMUL_LATENCY];

  assign alu_issue = issue_valid && (fu_code == FU_ALU || fu_code == FU_BR);
  assign mul_issue = issue_valid && (fu_code == FU_IMUL);

  alu alu_i (
    .op     (alu_op),
    .in1    (in1),
    .in2    (in2),
    .result (alu_out)
  );

  imul imul_i (
    .clock  (clock),
    .reset  (reset),
    .op     (mul_op),
    .in1    (in1),
    .in2    (in2),
    .result (mul_out)
  );

  always_ff @(posedge clock) begin
    if (alu_issue) begin
      alu_q <= alu_out;
    end
  end

  // Multiplies enter at the far end, ALU ops at the head slot
  always_ff @(posedge clock) begin
    if (reset) begin
      slot_valid <= '0;
    end else begin
      slot_valid[0] <= alu_issue | slot_valid[1];
      for (int i = 1; i < `IMUL_LATENCY - 1; i++) begin
        slot_valid[i] <= slot_valid[i+1];
      end
      slot_valid[`IMUL_LATENCY-1] <= mul_issue;
    end
  end

  always_ff @(posedge clock) begin
    slot_tag[0] <= alu_issue ? tag : slot_tag[1];
    slot_mul[0] <= !alu_issue && slot_mul[1];
    for (int i = 1; i < `IMUL_LATENCY - 1; i++) begin
      slot_tag[i] <= slot_tag[i+1];
      slot_mul[i] <= slot_mul[i+1];
    end
    slot_tag[`IMUL_LATENCY-1] <= tag;
    slot_mul[`IMUL_LATENCY-1] <= mul_issue;
  end

  assign result_valid = slot_valid[0];
  assign result_tag   = slot_tag[0];
  assign result       = slot_mul[0] ? mul_out : alu_q;
  // Next slot into the head is taken, so an ALU op now would collide
  assign alu_stall    = slot_valid[1];

endmodule

//--- rtl/mem_pipe.sv
//////////////////////////////
// Load/store pipe
// Address generation, byte lanes,
// request FSM, load extension
//////////////////////////////

`timescale 1ns/1ps
`include "exec_defines.svh"

module mem_pipe import uop_pkg::*, mem_pkg::*; (
  input             clock,
  input             reset,
  input             issue_valid,
  input  mem_kind_t mem_kind,
  input  mem_size_t mem_size,
  input  tag_t      tag,
  input  word_t     in1,
  input  word_t     in2,
  input  word_t     imm,
  output            busy,
  output            result_valid,
  output tag_t      result_tag,
  output word_t     result,
  output            dmem_req,
  output            dmem_we,
  output addr_t     dmem_addr,
  output byte_en_t  dmem_be,
  output word_t     dmem_wdata,
  input             dmem_rvalid,
  input  word_t     dmem_rdata
);

  mem_state_t state;
  addr_t      addr_q;
  mem_kind_t  kind_q;
  mem_size_t  size_q;
  tag_t       tag_q;
  word_t      data_q;
  word_t      result_q;
  logic [1:0] lane_off;
  byte_en_t   lane_mask;
  word_t      rdata_shift;
  logic       fill;
  word_t      load_ext;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= MS_IDLE;
    end else begin
      case (state)
        MS_IDLE: if (issue_valid) state <= MS_REQ;
        // Stores go through on the first request cycle
        MS_REQ:  if (kind_q == MEM_ST || dmem_rvalid) state <= MS_RESP;
        MS_RESP: state <= MS_IDLE;
        default: state <= MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == MS_IDLE && issue_valid) begin
      addr_q <= addr_t'(in1 + imm);
      kind_q <= mem_kind;
      size_q <= mem_size;
      tag_q  <= tag;
      data_q <= in2;
    end
    if (state == MS_REQ) begin
      if (kind_q == MEM_ST) begin
        result_q <= '0;
      end else if (dmem_rvalid) begin
        result_q <= load_ext;
      end
    end
  end

  // Lane position and store data replicated across the word
  always_comb begin
    case (size_q)
      MEM_BYTE: begin
        lane_off   = addr_q[1:0];
        lane_mask  = 4'b0001;
        dmem_wdata = {4{data_q[7:0]}};
      end
      MEM_HALF: begin
        lane_off   = {addr_q[1], 1'b0};
        lane_mask  = 4'b0011;
        dmem_wdata = {2{data_q[15:0]}};
      end
      default: begin
        lane_off   = 2'b00;
        lane_mask  = 4'b1111;
        dmem_wdata = data_q;
      end
    endcase
  end

  assign rdata_shift = dmem_rdata >> {lane_off, 3'b000};
  assign fill        = (kind_q == MEM_LD);

  always_comb begin
    case (size_q)
      MEM_BYTE: load_ext = {{24{fill & rdata_shift[7]}}, rdata_shift[7:0]};
      MEM_HALF: load_ext = {{16{fill & rdata_shift[15]}}, rdata_shift[15:0]};
      default:  load_ext = rdata_shift;
    endcase
  end

  assign busy         = (state != MS_IDLE);
  assign result_valid = (state == MS_RESP);
  assign result_tag   = tag_q;
  assign result       = result_q;
  assign dmem_req     = (state == MS_REQ);
  assign dmem_we      = dmem_req && (kind_q == MEM_ST);
  assign dmem_addr    = {addr_q[`ADDR_W-1:2], 2'b00};
  assign dmem_be      = lane_mask << lane_off;

endmodule

//--- rtl/mem_pkg.sv
//////////////////////////////
// Data memory access types
//////////////////////////////

`include "exec_defines.svh"

package mem_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [3:0]         byte_en_t;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } mem_size_t;

  typedef enum logic [1:0] {
    MEM_LD,
    MEM_LDU,
    MEM_ST
  } mem_kind_t;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_REQ,
    MS_RESP
  } mem_state_t;

endpackage

//--- rtl/uop_pkg.sv
//////////////////////////////
// Micro-op types
// Unit select, ALU and multiply
// opcodes, tag and data words
//////////////////////////////

`include "exec_defines.svh"

package uop_pkg;

  typedef logic [`XLEN-1:0]  word_t;
  typedef logic [`TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_BR,
    FU_IMUL,
    FU_MEM
  } fu_code_t;

  // Branch compares share the ALU opcode space
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE,
    ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_t;

  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHU
  } mul_op_t;

endpackage
